/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_slave
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TEST OK" $(LOG); then \
	  echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/i2c_bus_if.sv */
// Filtered I2C bus events
`timescale 1ns/1ps

interface i2c_bus_if;

  logic sda_level; // filtered sda
  logic scl_rise;
  logic scl_fall;
  logic start_det;
  logic stop_det;
  logic bus_busy;  // between start and stop

  modport src (
    output sda_level, scl_rise, scl_fall,
    output start_det, stop_det, bus_busy
  );

  modport snk (
    input sda_level, scl_rise, scl_fall,
    input start_det, stop_det, bus_busy
  );

endinterface

/* common/i2c_slave_pkg.sv */
// I2C slave shared definitions

package i2c_slave_pkg;

  // input lockout after an accepted line change, in clk cycles
  localparam int BACKOFF = 7;

  localparam int HOLD_W = 16; // hold counter width

  typedef logic [6:0] addr_t;
  typedef logic [7:0] byte_t;

  // control byte as sent on the wire, address in the upper bits
  typedef struct packed {
    addr_t addr;
    logic  rw_n; // 1 means read
  } ctrl_fields_t;

  // one received word, control view or plain data view
  typedef union packed {
    byte_t        raw;
    ctrl_fields_t ctrl;
  } ctrl_byte_u;

endpackage

/* common/i2c_tx_if.sv */
// I2C bit send handshake
`timescale 1ns/1ps

interface i2c_tx_if;

  logic send_strb;
  logic bit_val;
  logic last;      // release sda once the bit is held
  logic sent_strb;

  modport ctrl (
    output send_strb, bit_val, last,
    input  sent_strb
  );

  modport tx (
    input  send_strb, bit_val, last,
    output sent_strb
  );

endinterface

/* i2c_slave/i2c_bit_rx.sv */
// I2C bit receiver
`timescale 1ns/1ps

module i2c_bit_rx #(
  parameter int CLOCK_RATE = 10_000_000,
  parameter int FREQ       = 250_000
) (
  input  logic   clk,
  input  logic   reset,
  i2c_bus_if.snk bus,
  input  logic   get_strb_i,
  output logic   got_strb_o,
  output logic   bit_o
);

  localparam int HW         = i2c_slave_pkg::HOLD_W;
  localparam int BIT_CYCLES = CLOCK_RATE / FREQ;
  localparam logic [HW-1:0] HOLD_LOAD = HW'(BIT_CYCLES * 20 / 100 - 1); // strobe at hold+1

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RISE = 2'd1;
  localparam logic [1:0] S_FALL = 2'd2;
  localparam logic [1:0] S_WAIT = 2'd3;

  logic [1:0]    state;
  logic [HW-1:0] hold_cnt;

  always_ff @(posedge clk) begin
    if (reset || bus.start_det || bus.stop_det) begin
      state      <= S_IDLE;
      hold_cnt   <= '0;
      got_strb_o <= 1'b0;
    end else begin
      got_strb_o <= 1'b0;
      case (state)
        S_IDLE: begin
          if (get_strb_i) begin
            state <= S_RISE;
          end
        end
        S_RISE: begin
          if (bus.scl_rise) begin
            state <= S_FALL;
          end
        end
        S_FALL: begin
          if (bus.scl_fall) begin
            hold_cnt <= HOLD_LOAD;
            state    <= S_WAIT;
          end
        end
        default: begin
          if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
          end else begin
            got_strb_o <= 1'b1;
            state      <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_RISE && bus.scl_rise) begin
      bit_o <= bus.sda_level; // sample while scl high
    end
  end

endmodule

/* i2c_slave/i2c_bit_tx.sv */
// I2C bit transmitter
`timescale 1ns/1ps

module i2c_bit_tx #(
  parameter int CLOCK_RATE = 10_000_000,
  parameter int FREQ       = 250_000
) (
  input  logic   clk,
  input  logic   reset,
  i2c_bus_if.snk bus,
  i2c_tx_if.tx   txi,
  output logic   sda_oen_o
);

  localparam int HW         = i2c_slave_pkg::HOLD_W;
  localparam int BIT_CYCLES = CLOCK_RATE / FREQ;
  localparam logic [HW-1:0] HOLD_LOAD = HW'(BIT_CYCLES * 20 / 100 - 1);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_EDGE = 2'd1;
  localparam logic [1:0] S_WAIT = 2'd2;

  logic [1:0]    state;
  logic [HW-1:0] hold_cnt;
  logic          last_q;

  always_ff @(posedge clk) begin
    if (reset || bus.start_det || bus.stop_det) begin
      state         <= S_IDLE;
      hold_cnt      <= '0;
      txi.sent_strb <= 1'b0;
      sda_oen_o     <= 1'b1; // bus released
    end else begin
      txi.sent_strb <= 1'b0;
      case (state)
        S_IDLE: begin
          if (txi.send_strb) begin
            sda_oen_o <= txi.bit_val; // low pulls sda down
            state     <= S_EDGE;
          end
        end
        S_EDGE: begin
          if (bus.scl_fall) begin
            hold_cnt <= HOLD_LOAD;
            state    <= S_WAIT;
          end
        end
        default: begin
          if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
          end else begin
            txi.sent_strb <= 1'b1;
            if (last_q) begin
              sda_oen_o <= 1'b1;
            end
            state <= S_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && txi.send_strb) begin
      last_q <= txi.last;
    end
  end

  // controller waits for sent_strb before the next send
  a_send_when_idle: assert property (@(posedge clk) disable iff (reset)
    txi.send_strb |-> state == S_IDLE);

endmodule

/* i2c_slave/i2c_byte_ctrl.sv */
// I2C byte controller
`timescale 1ns/1ps

module i2c_byte_ctrl #(
  parameter i2c_slave_pkg::addr_t ADDRESS = 7'b0101010
) (
  input  logic                 clk,
  input  logic                 reset,
  i2c_bus_if.snk               bus,
  output logic                 get_strb_o,
  input  logic                 got_strb_i,
  input  logic                 bit_i,
  i2c_tx_if.ctrl               txi,
  input  i2c_slave_pkg::byte_t data_i,
  input  logic                 dstrb_i,
  output i2c_slave_pkg::byte_t data_o,
  output logic                 dstrb_o,
  output logic                 busy_o,
  output logic                 cmd_strb_o
);

  localparam logic [3:0] S_IDLE      = 4'd0;
  localparam logic [3:0] S_CTRL_READ = 4'd1;
  localparam logic [3:0] S_CTRL_PROC = 4'd2;
  localparam logic [3:0] S_CACK_WAIT = 4'd3;
  localparam logic [3:0] S_WORD_READ = 4'd4;
  localparam logic [3:0] S_WORD_PROC = 4'd5;
  localparam logic [3:0] S_DACK_WAIT = 4'd6;
  localparam logic [3:0] S_WORD_SEND = 4'd7;
  localparam logic [3:0] S_WORD_WAIT = 4'd8;
  localparam logic [3:0] S_MACK_READ = 4'd9;
  localparam logic [3:0] S_MACK_PROC = 4'd10;

  logic [3:0]                 state;
  logic [2:0]                 bit_idx;
  logic                       rw_n;
  logic                       run;
  logic                       byte_sent;
  logic                       busy_q;
  i2c_slave_pkg::byte_t       tx_data;
  i2c_slave_pkg::ctrl_byte_u  rx_word;
  i2c_slave_pkg::ctrl_byte_u  rx_next;

  assign run       = bus.bus_busy && !(bus.start_det || bus.stop_det);
  assign rx_next   = {rx_word.raw[6:0], bit_i}; // msb first
  assign byte_sent = run && state == S_WORD_SEND && bit_idx == 3'd7;

  always_ff @(posedge clk) begin
    if (reset || bus.start_det || bus.stop_det) begin
      state         <= S_CTRL_READ;
      bit_idx       <= 3'd0;
      rw_n          <= 1'b0;
      get_strb_o    <= 1'b0;
      txi.send_strb <= 1'b0;
      txi.bit_val   <= 1'b1;
      txi.last      <= 1'b1;
      dstrb_o       <= 1'b0;
      cmd_strb_o    <= 1'b0;
    end else if (bus.bus_busy) begin
      get_strb_o    <= 1'b0;
      txi.send_strb <= 1'b0;
      dstrb_o       <= 1'b0;
      cmd_strb_o    <= 1'b0;
      case (state)
        S_CTRL_READ, S_WORD_READ, S_MACK_READ: begin
          get_strb_o <= 1'b1;
          state      <= state + 4'd1; // matching proc state
        end
        S_CTRL_PROC: begin
          if (got_strb_i) begin
            if (bit_idx != 3'd7) begin
              bit_idx <= bit_idx + 3'd1;
              state   <= S_CTRL_READ;
            end else if (rx_next.ctrl.addr != ADDRESS) begin
              state <= S_IDLE; // wait for next start
            end else begin
              rw_n          <= rx_next.ctrl.rw_n;
              txi.send_strb <= 1'b1;
              txi.bit_val   <= 1'b0;
              txi.last      <= ~rx_next.ctrl.rw_n; // keep sda for read data
              state         <= S_CACK_WAIT;
            end
          end
        end
        S_CACK_WAIT: begin
          if (txi.sent_strb) begin
            cmd_strb_o <= 1'b1;
            bit_idx    <= 3'd0;
            state      <= rw_n ? S_WORD_SEND : S_WORD_READ;
          end
        end
        S_WORD_PROC: begin
          if (got_strb_i) begin
            if (bit_idx != 3'd7) begin
              bit_idx <= bit_idx + 3'd1;
              state   <= S_WORD_READ;
            end else begin
              dstrb_o       <= 1'b1;
              txi.send_strb <= 1'b1;
              txi.bit_val   <= 1'b0;
              txi.last      <= 1'b1;
              state         <= S_DACK_WAIT;
            end
          end
        end
        S_DACK_WAIT: begin
          if (txi.sent_strb) begin
            bit_idx <= 3'd0;
            state   <= S_WORD_READ;
          end
        end
        S_WORD_SEND: begin
          txi.send_strb <= 1'b1;
          txi.bit_val   <= tx_data[3'd7 - bit_idx];
          txi.last      <= (bit_idx == 3'd7);
          state         <= S_WORD_WAIT;
        end
        S_WORD_WAIT: begin
          if (txi.sent_strb) begin
            if (bit_idx == 3'd7) begin
              state <= S_MACK_READ;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              state   <= S_WORD_SEND;
            end
          end
        end
        S_MACK_PROC: begin
          if (got_strb_i) begin
            if (bit_i) begin
              state <= S_IDLE; // nack ends the read
            end else begin
              bit_idx <= 3'd0;
              state   <= S_WORD_SEND;
            end
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (run && got_strb_i && (state == S_CTRL_PROC || state == S_WORD_PROC)) begin
      rx_word <= rx_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
    end else if (dstrb_i) begin
      busy_q <= 1'b1; // new load keeps busy
    end else if (byte_sent) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dstrb_i) begin
      tx_data <= data_i;
    end
  end

  assign data_o = rx_word.raw;
  assign busy_o = dstrb_i | busy_q;

  a_no_rx_tx_overlap: assert property (@(posedge clk) disable iff (reset)
    !(dstrb_o && txi.sent_strb));

endmodule

/* i2c_slave/i2c_line_conditioner.sv */
// I2C line conditioner
`timescale 1ns/1ps

module i2c_line_conditioner (
  input  logic   clk,
  input  logic   reset,
  input  logic   scl_i,
  input  logic   sda_i,
  i2c_bus_if.src bus
);

  localparam int CNT_W = $clog2(i2c_slave_pkg::BACKOFF + 1);
  localparam logic [CNT_W-1:0] LOCKOUT = CNT_W'(i2c_slave_pkg::BACKOFF);

  logic [CNT_W-1:0] scl_cnt;
  logic [CNT_W-1:0] sda_cnt;
  logic             scl_lvl;
  logic             sda_lvl;
  logic             scl_prev;
  logic             sda_prev;
  logic             busy_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      scl_cnt       <= '0;
      sda_cnt       <= '0;
      scl_lvl       <= 1'b1; // idle bus is high
      sda_lvl       <= 1'b1;
      scl_prev      <= 1'b1;
      sda_prev      <= 1'b1;
      bus.scl_rise  <= 1'b0;
      bus.scl_fall  <= 1'b0;
      bus.start_det <= 1'b0;
      bus.stop_det  <= 1'b0;
      busy_q        <= 1'b0;
    end else begin
      if (scl_cnt != '0) begin
        scl_cnt <= scl_cnt - 1'b1;
      end else if (scl_i != scl_lvl) begin
        scl_lvl <= scl_i;
        scl_cnt <= LOCKOUT;
      end
      if (sda_cnt != '0) begin
        sda_cnt <= sda_cnt - 1'b1;
      end else if (sda_i != sda_lvl) begin
        sda_lvl <= sda_i;
        sda_cnt <= LOCKOUT;
      end
      scl_prev      <= scl_lvl;
      sda_prev      <= sda_lvl;
      bus.scl_rise  <= scl_lvl & ~scl_prev;
      bus.scl_fall  <= ~scl_lvl & scl_prev;
      bus.start_det <= ~sda_lvl & sda_prev & scl_lvl; // sda falls, scl high
      bus.stop_det  <= sda_lvl & ~sda_prev & scl_lvl;
      if (bus.start_det) begin
        busy_q <= 1'b1;
      end else if (bus.stop_det) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign bus.sda_level = sda_lvl;
  assign bus.bus_busy  = busy_q;

  // sda must settle before scl rises
  a_cond_not_on_rise: assert property (@(posedge clk) disable iff (reset)
    !((bus.start_det || bus.stop_det) && bus.scl_rise));

endmodule

/* list.f */
common/i2c_slave_pkg.sv
common/i2c_bus_if.sv
common/i2c_tx_if.sv
i2c_slave/i2c_line_conditioner.sv
i2c_slave/i2c_bit_rx.sv
i2c_slave/i2c_bit_tx.sv
i2c_slave/i2c_byte_ctrl.sv
verilog/i2c_slave_top.sv
test/tb_clock_gen.sv
test/tb_i2c_slave.sv

/* test/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o); // release on the falling edge like other inputs
    reset_o = 1'b0;
  end

endmodule

/* test/tb_i2c_slave.sv */
// I2C slave testbench
`timescale 1ns/1ps

module tb_i2c_slave;

  localparam int QTR          = 10; // clk cycles per quarter scl period
  localparam int RANDOM_TRANS = 14;
  localparam int TIMEOUT_CYCLES = 20 * 6 * 9 * 40 + 5000;
  localparam i2c_slave_pkg::addr_t SLAVE_ADDR = 7'b0101010;

  logic                 clk;
  logic                 reset;
  logic                 scl;
  logic                 sda_m;  // master side of the wired-and
  logic                 sda;
  logic                 sda_oen_o;
  i2c_slave_pkg::byte_t data_i;
  logic                 dstrb_i;
  i2c_slave_pkg::byte_t data_o;
  logic                 dstrb_o;
  logic                 busy_o;
  logic                 cmd_strb_o;
  logic                 watch_release;

  int seed = 77068;
  int err_count = 0;
  int check_count = 0;
  int cmd_count = 0;
  int cycle_count = 0;
  i2c_slave_pkg::byte_t exp_q[$]; // written bytes still owed on dstrb_o
  i2c_slave_pkg::byte_t host_byte;

  assign sda = sda_m & sda_oen_o;

  tb_clock_gen clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  i2c_slave_top DUT (
    .clk        (clk),
    .reset      (reset),
    .scl_i      (scl),
    .sda_i      (sda),
    .sda_oen_o  (sda_oen_o),
    .data_i     (data_i),
    .dstrb_i    (dstrb_i),
    .data_o     (data_o),
    .dstrb_o    (dstrb_o),
    .busy_o     (busy_o),
    .cmd_strb_o (cmd_strb_o)
  );

  task automatic check_byte(input string name, input i2c_slave_pkg::byte_t got,
                            input i2c_slave_pkg::byte_t exp);
    check_count++;
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic expect_cmd_count(input int exp);
    check_count++;
    if (cmd_count != exp) begin
      $display("ERROR at %0t: cmd_strb_o pulsed %0d times in total, %0d expected",
               $time, cmd_count, exp);
      err_count++;
    end
  endtask

  function automatic int rand_below(input int range);
    int r;
    r = $random(seed);
    return int'($unsigned(r) % range);
  endfunction

  // one scl period, data set in the low phase, sampled mid high
  task automatic clock_bit(input logic b, output logic s);
    repeat (QTR) @(negedge clk);
    sda_m = b;
    repeat (QTR) @(negedge clk);
    scl = 1'b1;
    repeat (QTR) @(negedge clk);
    s = sda;
    repeat (QTR) @(negedge clk);
    scl = 1'b0;
  endtask

  task automatic start_cond();
    if (scl == 1'b0) begin // repeated start
      repeat (QTR) @(negedge clk);
      sda_m = 1'b1;
      repeat (QTR) @(negedge clk);
      scl = 1'b1;
    end
    repeat (QTR) @(negedge clk);
    sda_m = 1'b0;
    repeat (QTR) @(negedge clk);
    scl = 1'b0;
  endtask

  task automatic stop_cond();
    repeat (QTR) @(negedge clk);
    sda_m = 1'b0;
    repeat (QTR) @(negedge clk);
    scl = 1'b1;
    repeat (QTR) @(negedge clk);
    sda_m = 1'b1;
    repeat (2 * QTR + i2c_slave_pkg::BACKOFF) @(negedge clk); // bus idle gap
  endtask

  task automatic write_byte(input i2c_slave_pkg::byte_t b, output logic ack);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], s);
    end
    clock_bit(1'b1, ack); // released for the slave ack
  endtask

  task automatic read_byte(output i2c_slave_pkg::byte_t b);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, s);
      b[i] = s;
    end
  endtask

  task automatic load_byte(input i2c_slave_pkg::byte_t b);
    data_i  = b;
    dstrb_i = 1'b1;
    @(negedge clk);
    dstrb_i = 1'b0;
    @(negedge clk);
    check_bit("busy_o", busy_o, 1'b1);
  endtask

  task automatic write_transfer(input int n);
    i2c_slave_pkg::ctrl_byte_u cb;
    i2c_slave_pkg::byte_t      b;
    logic                      ack;
    int                        cmd_before;
    cmd_before   = cmd_count;
    cb.ctrl.addr = SLAVE_ADDR;
    cb.ctrl.rw_n = 1'b0;
    start_cond();
    write_byte(cb.raw, ack);
    check_bit("ctrl ack", ack, 1'b0);
    for (int i = 0; i < n; i++) begin
      b = i2c_slave_pkg::byte_t'(rand_below(256));
      exp_q.push_back(b);
      write_byte(b, ack);
      check_bit("data ack", ack, 1'b0);
    end
    stop_cond();
    expect_cmd_count(cmd_before + 1);
    if (exp_q.size() != 0) begin
      $display("ERROR at %0t: %0d written bytes never came out on dstrb_o",
               $time, exp_q.size());
      err_count++;
      exp_q.delete();
    end
  endtask

  task automatic ignored_transfer(input int n);
    i2c_slave_pkg::ctrl_byte_u cb;
    i2c_slave_pkg::addr_t      a;
    logic                      ack;
    int                        cmd_before;
    int                        r;
    cmd_before = cmd_count;
    a = i2c_slave_pkg::addr_t'(rand_below(128));
    if (a == SLAVE_ADDR) begin
      a = a ^ 7'h01;
    end
    r            = rand_below(2);
    cb.ctrl.addr = a;
    cb.ctrl.rw_n = r[0];
    watch_release = 1'b1;
    start_cond();
    write_byte(cb.raw, ack);
    check_bit("ctrl ack", ack, 1'b1);
    for (int i = 0; i < n; i++) begin
      write_byte(i2c_slave_pkg::byte_t'(rand_below(256)), ack);
      check_bit("data ack", ack, 1'b1);
    end
    stop_cond();
    watch_release = 1'b0;
    expect_cmd_count(cmd_before);
  endtask

  task automatic read_transfer(input int n, input logic reload);
    i2c_slave_pkg::ctrl_byte_u cb;
    i2c_slave_pkg::byte_t      got;
    i2c_slave_pkg::byte_t      fresh;
    logic                      ack;
    logic                      dummy;
    int                        cmd_before;
    cmd_before = cmd_count;
    host_byte  = i2c_slave_pkg::byte_t'(rand_below(256));
    load_byte(host_byte);
    cb.ctrl.addr = SLAVE_ADDR;
    cb.ctrl.rw_n = 1'b1;
    start_cond();
    write_byte(cb.raw, ack);
    check_bit("ctrl ack", ack, 1'b0);
    for (int i = 0; i < n; i++) begin
      read_byte(got);
      check_byte("read data", got, host_byte); // last loaded byte
      check_bit("busy_o", busy_o, 1'b0);
      if (i == n - 1) begin
        clock_bit(1'b1, dummy); // nack
        check_bit("sda_oen_o", sda_oen_o, 1'b1);
      end else if (reload) begin
        fresh = i2c_slave_pkg::byte_t'(rand_below(256));
        fork
          load_byte(fresh);
          clock_bit(1'b0, dummy);
        join
        host_byte = fresh;
      end else begin
        clock_bit(1'b0, dummy);
      end
    end
    stop_cond();
    expect_cmd_count(cmd_before + 1);
  endtask

  // address phase, part of a data byte, then a repeated start
  task automatic restart_mid_byte();
    i2c_slave_pkg::ctrl_byte_u cb;
    logic                      ack;
    logic                      s;
    int                        cmd_before;
    cmd_before   = cmd_count;
    cb.ctrl.addr = SLAVE_ADDR;
    cb.ctrl.rw_n = 1'b0;
    start_cond();
    write_byte(cb.raw, ack);
    check_bit("ctrl ack", ack, 1'b0);
    for (int i = 0; i < 3; i++) begin
      clock_bit(logic'(rand_below(2)), s);
    end
    expect_cmd_count(cmd_before + 1);
    write_transfer(1 + rand_below(4));
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      if (cmd_strb_o) begin
        cmd_count++;
      end
      if (dstrb_o) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: dstrb_o pulsed with no byte expected", $time);
          err_count++;
        end else begin
          check_byte("data_o", data_o, exp_q.pop_front());
        end
      end
      if (watch_release) begin
        check_bit("sda_oen_o", sda_oen_o, 1'b1);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int kind;
    scl           = 1'b1;
    sda_m         = 1'b1;
    data_i        = '0;
    dstrb_i       = 1'b0;
    watch_release = 1'b0;
    wait (reset == 1'b0);
    @(negedge clk);
    check_bit("sda_oen_o", sda_oen_o, 1'b1);
    check_bit("dstrb_o", dstrb_o, 1'b0);
    check_bit("cmd_strb_o", cmd_strb_o, 1'b0);
    check_bit("busy_o", busy_o, 1'b0);
    repeat (2 * QTR) @(negedge clk);
    write_transfer(3);
    ignored_transfer(2);
    read_transfer(3, 1'b1);
    read_transfer(2, 1'b0); // one load, same byte twice
    restart_mid_byte();
    for (int t = 0; t < RANDOM_TRANS; t++) begin
      kind = rand_below(3);
      case (kind)
        0: write_transfer(1 + rand_below(4));
        1: ignored_transfer(1 + rand_below(4));
        default: read_transfer(1 + rand_below(4), 1'b1);
      endcase
    end
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog/i2c_slave_top.sv */
// I2C slave top level
`timescale 1ns/1ps

module i2c_slave_top #(
  parameter int                   CLOCK_RATE = 10_000_000,
  parameter int                   FREQ       = 250_000,
  parameter i2c_slave_pkg::addr_t ADDRESS    = 7'b0101010
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 scl_i,
  input  logic                 sda_i,
  output logic                 sda_oen_o,
  input  i2c_slave_pkg::byte_t data_i,
  input  logic                 dstrb_i,
  output i2c_slave_pkg::byte_t data_o,
  output logic                 dstrb_o,
  output logic                 busy_o,
  output logic                 cmd_strb_o
);

  logic get_strb;
  logic got_strb;
  logic rx_bit;

  i2c_bus_if bus ();
  i2c_tx_if  txi ();

  i2c_line_conditioner u_cond (
    .clk   (clk),
    .reset (reset),
    .scl_i (scl_i),
    .sda_i (sda_i),
    .bus   (bus.src)
  );

  i2c_bit_rx #(.CLOCK_RATE(CLOCK_RATE), .FREQ(FREQ)) u_rx (
    .clk        (clk),
    .reset      (reset),
    .bus        (bus.snk),
    .get_strb_i (get_strb),
    .got_strb_o (got_strb),
    .bit_o      (rx_bit)
  );

  i2c_bit_tx #(.CLOCK_RATE(CLOCK_RATE), .FREQ(FREQ)) u_tx (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus.snk),
    .txi       (txi.tx),
    .sda_oen_o (sda_oen_o)
  );

  i2c_byte_ctrl #(.ADDRESS(ADDRESS)) u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .bus        (bus.snk),
    .get_strb_o (get_strb),
    .got_strb_i (got_strb),
    .bit_i      (rx_bit),
    .txi        (txi.ctrl),
    .data_i     (data_i),
    .dstrb_i    (dstrb_i),
    .data_o     (data_o),
    .dstrb_o    (dstrb_o),
    .busy_o     (busy_o),
    .cmd_strb_o (cmd_strb_o)
  );

endmodule
